// File: hdl/div_pkg.sv
// ==================================================
// shared types and widths for the rv64 divider
// op codes, request, prepared job and raw result
// referenced by scoped names from every module
// ==================================================

`default_nettype none

package div_pkg;

  // ================================================
  // widths
  // ================================================
  localparam int unsigned XLEN  = 64;
  localparam int unsigned HALF  = 32;  // word ops
  localparam int unsigned CNT_W = 7;   // holds 64

  // bit 2 remainder, bit 1 word, bit 0 unsigned
  typedef enum logic [2:0] {
    OP_DIV   = 3'b000,
    OP_DIVU  = 3'b001,
    OP_DIVW  = 3'b010,
    OP_DIVUW = 3'b011,
    OP_REM   = 3'b100,
    OP_REMU  = 3'b101,
    OP_REMW  = 3'b110,
    OP_REMUW = 3'b111
  } div_op_e;

  // ================================================
  // transfer structs
  // ================================================
  typedef struct packed {
    div_op_e         op;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
  } div_req_t;

  // unsigned job for the core
  typedef struct packed {
    logic [XLEN-1:0]  abs_dividend;  // left-aligned for word ops
    logic [XLEN-1:0]  abs_divisor;
    logic [CNT_W-1:0] iter_count;
    logic             neg_quot;
    logic             neg_rem;
    logic             is_word;
    logic             want_rem;
  } div_job_t;

  typedef struct packed {
    logic [XLEN-1:0] quotient;   // final value when bypass set
    logic [XLEN-1:0] remainder;
    logic            neg_quot;
    logic            neg_rem;
    logic            is_word;
    logic            want_rem;
    logic            bypass;
  } div_raw_t;

endpackage

`default_nettype wire

// File: hdl/div_prep.sv
// ==================================================
// request side of the divider
// four-phase slave, op decode, special cases
// stages one job or one bypass result for the core
// ==================================================

`default_nettype none

module div_prep (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                req_i,
  output logic               ack_o,
  input  wire div_pkg::div_req_t req_data_i,
  output logic               job_valid_o,
  output div_pkg::div_job_t  job_o,
  input  wire                job_ready_i,
  output logic               bypass_valid_o,
  output div_pkg::div_raw_t  bypass_o
);

  logic                      signed_op, is_word, want_rem;
  logic [div_pkg::XLEN-1:0]  a_ext, b_ext, a_abs, b_abs, a_min, spec_val;
  logic                      a_neg, b_neg, div_zero, ovf;
  logic                      stg_valid, stg_byp;
  logic                      accept;

  // ================================================
  // decode, straight from the request bus
  // ================================================
  assign signed_op = ~req_data_i.op[0];
  assign is_word   = req_data_i.op[1];
  assign want_rem  = req_data_i.op[2];

  assign a_ext = is_word ? {{div_pkg::HALF{req_data_i.dividend[div_pkg::HALF-1]}},
                            req_data_i.dividend[div_pkg::HALF-1:0]} : req_data_i.dividend;
  assign b_ext = is_word ? {{div_pkg::HALF{req_data_i.divisor[div_pkg::HALF-1]}},
                            req_data_i.divisor[div_pkg::HALF-1:0]} : req_data_i.divisor;

  assign a_neg = signed_op & a_ext[div_pkg::XLEN-1];
  assign b_neg = signed_op & b_ext[div_pkg::XLEN-1];
  assign a_abs = a_neg ? -a_ext : a_ext;
  assign b_abs = b_neg ? -b_ext : b_ext;

  // most negative value, 64 or 32 bit form
  assign a_min    = is_word ? {{(div_pkg::HALF+1){1'b1}}, {(div_pkg::HALF-1){1'b0}}}
                            : {1'b1, {(div_pkg::XLEN-1){1'b0}}};
  assign div_zero = (b_ext == '0);
  assign ovf      = signed_op & (a_ext == a_min) & (&b_ext);

  // architectural result for the two special cases
  always_comb begin
    if (div_zero) spec_val = want_rem ? a_ext : '1;
    else          spec_val = want_rem ? '0 : a_ext;
  end

  // ================================================
  // four-phase slave and staging register
  // ================================================
  assign accept = req_i & ~ack_o & ~stg_valid;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      ack_o     <= 1'b0;
      stg_valid <= 1'b0;
    end else begin
      if (stg_valid && job_ready_i) stg_valid <= 1'b0;  // core took it
      if (accept) begin
        ack_o     <= 1'b1;
        stg_valid <= 1'b1;
      end else if (!req_i) begin
        ack_o <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      stg_byp <= div_zero | ovf;
      job_o   <= '{abs_dividend: is_word ? {a_abs[div_pkg::HALF-1:0], {div_pkg::HALF{1'b0}}}
                                         : a_abs,
                   abs_divisor:  is_word ? {{div_pkg::HALF{1'b0}}, b_abs[div_pkg::HALF-1:0]}
                                         : b_abs,
                   iter_count:   is_word ? div_pkg::CNT_W'(div_pkg::HALF)
                                         : div_pkg::CNT_W'(div_pkg::XLEN),
                   neg_quot:     a_neg ^ b_neg,
                   neg_rem:      a_neg,
                   is_word:      is_word,
                   want_rem:     want_rem};
      bypass_o <= '{quotient: spec_val, remainder: '0, neg_quot: 1'b0, neg_rem: 1'b0,
                    is_word: is_word, want_rem: want_rem, bypass: 1'b1};
    end
  end

  assign job_valid_o    = stg_valid & ~stg_byp;  // never both
  assign bypass_valid_o = stg_valid & stg_byp;

endmodule

`default_nettype wire

// File: hdl/div_core.sv
// ==================================================
// restoring shift-subtract divider core
// one quotient bit per clock on unsigned operands
// bypass results go to the fifo through the same port
// ==================================================

`default_nettype none

module div_core (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    job_valid_i,
  input  wire div_pkg::div_job_t job_i,
  output logic                   job_ready_o,
  input  wire                    bypass_valid_i,
  input  wire div_pkg::div_raw_t bypass_i,
  output logic                   wr_en_o,
  output div_pkg::div_raw_t      wr_data_o,
  input  wire                    full_i
);

  typedef enum logic [1:0] {
    C_IDLE,
    C_ITER,
    C_FIN
  } state_e;

  state_e                        state_q;
  logic [2*div_pkg::XLEN-1:0]    rq_q;      // remainder:quotient
  logic [div_pkg::XLEN-1:0]      dvs_q;
  logic [div_pkg::CNT_W-1:0]     cnt_q;
  logic [3:0]                    flags_q;   // neg_quot, neg_rem, is_word, want_rem
  logic                          byp_sel_q;
  div_pkg::div_raw_t             byp_q;
  logic [div_pkg::XLEN:0]        diff;

  // trial subtract on the shifted upper half
  assign diff = rq_q[2*div_pkg::XLEN-1:div_pkg::XLEN-1] - {1'b0, dvs_q};

  // ================================================
  // state machine
  // ================================================
  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q   <= C_IDLE;
      cnt_q     <= '0;
      byp_sel_q <= 1'b0;
    end else begin
      case (state_q)
        C_IDLE: begin
          if (bypass_valid_i) begin
            byp_sel_q <= 1'b1;
            state_q   <= C_FIN;
          end else if (job_valid_i) begin
            byp_sel_q <= 1'b0;
            cnt_q     <= job_i.iter_count;
            state_q   <= C_ITER;
          end
        end
        C_ITER: begin
          cnt_q <= cnt_q - 1'b1;
          if (cnt_q == div_pkg::CNT_W'(1)) state_q <= C_FIN;
        end
        C_FIN: if (!full_i) state_q <= C_IDLE;  // hold until fifo has room
        default: state_q <= C_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk) begin
    if (state_q == C_IDLE) begin
      byp_q   <= bypass_i;
      rq_q    <= {{div_pkg::XLEN{1'b0}}, job_i.abs_dividend};
      dvs_q   <= job_i.abs_divisor;
      flags_q <= {job_i.neg_quot, job_i.neg_rem, job_i.is_word, job_i.want_rem};
    end else if (state_q == C_ITER) begin
      if (diff[div_pkg::XLEN]) rq_q <= {rq_q[2*div_pkg::XLEN-2:0], 1'b0};  // restore
      else rq_q <= {diff[div_pkg::XLEN-1:0], rq_q[div_pkg::XLEN-2:0], 1'b1};
    end
  end

  // ================================================
  // output stage
  // ================================================
  assign job_ready_o = (state_q == C_IDLE);
  assign wr_en_o     = (state_q == C_FIN) & ~full_i;

  always_comb begin
    if (byp_sel_q) wr_data_o = byp_q;
    else wr_data_o = '{quotient:  rq_q[div_pkg::XLEN-1:0],
                       remainder: rq_q[2*div_pkg::XLEN-1:div_pkg::XLEN],
                       neg_quot:  flags_q[3],
                       neg_rem:   flags_q[2],
                       is_word:   flags_q[1],
                       want_rem:  flags_q[0],
                       bypass:    1'b0};
  end

endmodule

`default_nettype wire

// File: hdl/div_result_fifo.sv
// ==================================================
// in-order buffer of raw results
// sits between the core and the result formatter
// DEPTH must be a power of two, 2 or more
// ==================================================

`default_nettype none

module div_result_fifo #(
  parameter int unsigned DEPTH = 4
) (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    wr_en_i,
  input  wire div_pkg::div_raw_t wr_data_i,
  output logic                   full_o,
  input  wire                    rd_en_i,
  output logic                   rd_valid_o,
  output div_pkg::div_raw_t      rd_data_o
);

  localparam int unsigned AW = $clog2(DEPTH);

  div_pkg::div_raw_t mem [DEPTH];
  logic [AW-1:0]     wr_ptr, rd_ptr;
  logic [AW:0]       count;
  logic              do_wr, do_rd;

  assign do_wr = wr_en_i & ~full_o;
  assign do_rd = rd_en_i & rd_valid_o;

  // pointers wrap on their own width
  always_ff @(posedge clk) begin
    if (rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      if (do_wr && !do_rd)      count <= count + 1'b1;
      else if (do_rd && !do_wr) count <= count - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data_i;
  end

  assign full_o     = (count == (AW+1)'(DEPTH));
  assign rd_valid_o = (count != '0);
  assign rd_data_o  = mem[rd_ptr];  // show-ahead

endmodule

`default_nettype wire

// File: hdl/div_post.sv
// ==================================================
// result formatting and four-phase result master
// restores signs, picks quotient or remainder
// sign-extends word results
// ==================================================

`default_nettype none

module div_post (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          rd_valid_i,
  input  wire div_pkg::div_raw_t       rd_data_i,
  output logic                         rd_en_o,
  output logic                         res_req_o,
  input  wire                          res_ack_i,
  output logic [div_pkg::XLEN-1:0]     res_data_o
);

  typedef enum logic [1:0] {
    P_IDLE,
    P_REQ,
    P_DROP
  } state_e;

  state_e                    state_q;
  logic [div_pkg::XLEN-1:0]  val, mag, fmt;
  logic                      neg;

  // ================================================
  // formatting
  // ================================================
  assign val = rd_data_i.want_rem ? rd_data_i.remainder : rd_data_i.quotient;
  assign neg = rd_data_i.want_rem ? rd_data_i.neg_rem : rd_data_i.neg_quot;
  assign mag = neg ? -val : val;

  always_comb begin
    if (rd_data_i.bypass)       fmt = rd_data_i.quotient;  // already final
    else if (rd_data_i.is_word) fmt = {{div_pkg::HALF{mag[div_pkg::HALF-1]}},
                                       mag[div_pkg::HALF-1:0]};
    else                        fmt = mag;
  end

  // ================================================
  // four-phase master
  // ================================================
  assign rd_en_o = (state_q == P_IDLE) & rd_valid_i;

  always_ff @(posedge clk) begin
    if (rst_n) begin
      state_q   <= P_IDLE;
      res_req_o <= 1'b0;
    end else begin
      case (state_q)
        P_IDLE: if (rd_valid_i) begin
          res_req_o <= 1'b1;
          state_q   <= P_REQ;
        end
        P_REQ: if (res_ack_i) begin
          res_req_o <= 1'b0;
          state_q   <= P_DROP;
        end
        P_DROP: if (!res_ack_i) state_q <= P_IDLE;  // ack low again
        default: state_q <= P_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_o) res_data_o <= fmt;
  end

endmodule

`default_nettype wire

// File: hdl/div_unit.sv
// ==================================================
// top level of the rv64 M-extension divider
// four-phase request in, four-phase result out
// FIFO_DEPTH sets the result buffer size
// ==================================================

`default_nettype none

module div_unit #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      req_i,
  output logic                     ack_o,
  input  wire div_pkg::div_req_t   req_data_i,
  output logic                     res_req_o,
  input  wire                      res_ack_i,
  output logic [div_pkg::XLEN-1:0] res_data_o
);

  logic              job_valid, job_ready, bypass_valid;
  div_pkg::div_job_t job;
  div_pkg::div_raw_t bypass, wr_data, rd_data;
  logic              wr_en, full, rd_valid, rd_en;

  div_prep u_prep (
    .clk(clk), .rst_n(rst_n),
    .req_i(req_i), .ack_o(ack_o), .req_data_i(req_data_i),
    .job_valid_o(job_valid), .job_o(job), .job_ready_i(job_ready),
    .bypass_valid_o(bypass_valid), .bypass_o(bypass)
  );

  div_core u_core (
    .clk(clk), .rst_n(rst_n),
    .job_valid_i(job_valid), .job_i(job), .job_ready_o(job_ready),
    .bypass_valid_i(bypass_valid), .bypass_i(bypass),
    .wr_en_o(wr_en), .wr_data_o(wr_data), .full_i(full)
  );

  div_result_fifo #(.DEPTH(FIFO_DEPTH)) u_fifo (
    .clk(clk), .rst_n(rst_n),
    .wr_en_i(wr_en), .wr_data_i(wr_data), .full_o(full),
    .rd_en_i(rd_en), .rd_valid_o(rd_valid), .rd_data_o(rd_data)
  );

  div_post u_post (
    .clk(clk), .rst_n(rst_n),
    .rd_valid_i(rd_valid), .rd_data_i(rd_data), .rd_en_o(rd_en),
    .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_data_o(res_data_o)
  );

endmodule

`default_nettype wire

// File: testbench/div_model.svh
// ==================================================
// reference model for the divider testbench
// rv64 M-extension results for all eight ops,
// divide by zero and signed overflow included
// included inside the testbench module
// ==================================================

`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

function automatic logic [63:0] sext_word(input logic [31:0] w);
  return {{32{w[31]}}, w};
endfunction

function automatic logic [63:0] model_result(input div_pkg::div_op_e op,
                                             input logic [63:0] a,
                                             input logic [63:0] b);
  logic   want_rem;
  logic   is_word;
  logic   is_uns;
  int     sa32;
  int     sb32;
  longint sa;
  longint sb;
  want_rem = op[2];
  is_word  = op[1];
  is_uns   = op[0];
  sa32 = a[31:0];
  sb32 = b[31:0];
  sa   = a;
  sb   = b;
  if (is_word) begin
    if (b[31:0] == 32'h0) return want_rem ? sext_word(a[31:0]) : '1;
    if (is_uns) return sext_word(want_rem ? a[31:0] % b[31:0] : a[31:0] / b[31:0]);
    if (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff)
      return want_rem ? 64'h0 : sext_word(a[31:0]);  // overflow
    return sext_word(want_rem ? 32'(sa32 % sb32) : 32'(sa32 / sb32));
  end
  if (b == 64'h0) return want_rem ? a : '1;
  if (is_uns) return want_rem ? a % b : a / b;
  if (a == 64'h8000_0000_0000_0000 && b == '1) return want_rem ? 64'h0 : a;
  return want_rem ? 64'(sa % sb) : 64'(sa / sb);  // truncates toward zero
endfunction

`endif

// File: testbench/div_unit_tb.sv
// ==================================================
// testbench for the rv64 divider
// random ops from an xorshift source, four-phase
// drivers on both sides, results checked in order
// ==================================================

`default_nettype none

module div_unit_tb;

  localparam int TIMEOUT   = 2000;  // cycles per wait
  localparam int PH_RANDOM = 0;
  localparam int PH_ZERO   = 1;
  localparam int PH_OVF    = 2;
  localparam int PH_SIGN   = 3;

  logic              clk, rst_n, req_i, res_ack_i;
  logic              ack_o, res_req_o;
  div_pkg::div_req_t req_data_i;
  logic [63:0]       res_data_o;
  logic [63:0]       exp_q[$];  // scoreboard, request order
  div_pkg::div_op_e  op_q[$];
  logic [63:0]       drv_rng, ack_rng;
  int                req_count, resp_count;

  `include "div_model.svh"

  div_unit uut (
    .clk(clk), .rst_n(rst_n),
    .req_i(req_i), .ack_o(ack_o), .req_data_i(req_data_i),
    .res_req_o(res_req_o), .res_ack_i(res_ack_i), .res_data_o(res_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 7);
    x = x ^ (x << 17);
    return x;
  endfunction

  // ================================================
  // checking and failure
  // ================================================
  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("CHECK FAILED at time %0t: %s, got %h expected %h", $time, what, got, exp);
      $display("Test FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic stop_with_error(input string why);
    $display("error at time %0t: %s", $time, why);
    $display("Test FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic wait_ack(input logic level);
    int n;
    n = 0;
    while (ack_o !== level) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) stop_with_error("no ack from divider");
    end
  endtask

  task automatic wait_res_req(input logic level);
    int n;
    n = 0;
    while (res_req_o !== level) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) stop_with_error("no result from divider");
    end
  endtask

  // quotient sign is a^b, remainder sign follows the dividend
  task automatic check_sign_rule(input div_pkg::div_op_e op, input logic [63:0] a,
                                 input logic [63:0] b);
    logic [63:0] r;
    int          top;
    r   = model_result(op, a, b);
    top = op[1] ? 31 : 63;
    if (!op[0] && r != 64'h0) begin
      if (op[2]) check_value(64'(r[top]), 64'(a[top]), "remainder sign");
      else check_value(64'(r[top]), 64'(a[top] ^ b[top]), "quotient sign");
    end
  endtask

  // ================================================
  // request and result sides
  // ================================================
  task automatic send_request(input div_pkg::div_op_e op, input logic [63:0] a,
                              input logic [63:0] b);
    exp_q.push_back(model_result(op, a, b));
    op_q.push_back(op);
    req_count++;
    @(posedge clk);
    req_data_i <= '{op: op, dividend: a, divisor: b};
    req_i      <= 1'b1;
    wait_ack(1'b1);
    req_i <= 1'b0;
    wait_ack(1'b0);
  endtask

  task automatic drive_phase(input int kind, input int n);
    div_pkg::div_op_e op;
    logic [63:0]      a, b, r;
    int               i;
    for (i = 0; i < n; i++) begin
      drv_rng = xorshift(drv_rng);
      a       = drv_rng;
      drv_rng = xorshift(drv_rng);
      r       = drv_rng;
      b       = r >> r[5:0];  // spread divisor sizes
      op      = div_pkg::div_op_e'(r[63:61]);
      case (kind)
        PH_ZERO: begin
          op = div_pkg::div_op_e'(i[2:0]);
          b  = op[1] ? {r[63:32], 32'h0} : 64'h0;  // junk high half on word ops
        end
        PH_OVF: begin
          op = div_pkg::div_op_e'({i[1:0], 1'b0});  // signed ops only
          a  = op[1] ? {a[63:32], 32'h8000_0000} : 64'h8000_0000_0000_0000;
          b  = op[1] ? {r[63:32], 32'hffff_ffff} : '1;
        end
        PH_SIGN: begin
          op    = div_pkg::div_op_e'(i[2:0]);
          a[63] = i[3];
          a[31] = i[3];
          b[63] = i[4];
          b[31] = i[4];
          b[0]  = 1'b1;  // keep clear of divide by zero
          check_sign_rule(op, a, b);
        end
        default: ;
      endcase
      send_request(op, a, b);
    end
  endtask

  task automatic collect(input int n, input int hold);
    logic [63:0]      got, exp;
    div_pkg::div_op_e op;
    int               i, delay;
    for (i = 0; i < n; i++) begin
      wait_res_req(1'b1);
      got = res_data_o;
      if (exp_q.size() == 0) stop_with_error("result with no request outstanding");
      exp = exp_q.pop_front();
      op  = op_q.pop_front();
      check_value(got, exp, $sformatf("op %s", op.name()));
      resp_count++;
      ack_rng = xorshift(ack_rng);
      delay   = (i == 0 && hold > 0) ? hold : int'(ack_rng[2:0]);
      repeat (delay) @(posedge clk);
      res_ack_i <= 1'b1;
      wait_res_req(1'b0);
      res_ack_i <= 1'b0;
    end
  endtask

  task automatic run_phase(input int kind, input int n, input int hold);
    fork
      drive_phase(kind, n);
      collect(n, hold);
    join
  endtask

  // ================================================
  // main sequence
  // ================================================
  initial begin
    rst_n      = 1'b1;
    req_i      = 1'b0;
    res_ack_i  = 1'b0;
    req_data_i = '0;
    drv_rng    = 64'd14;
    ack_rng    = xorshift(64'd14);
    req_count  = 0;
    resp_count = 0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b0;
    repeat (2) @(posedge clk);
    run_phase(PH_RANDOM, 200, 0);
    run_phase(PH_ZERO, 16, 0);
    run_phase(PH_OVF, 8, 0);
    run_phase(PH_SIGN, 32, 0);
    run_phase(PH_ZERO, 24, 40);  // one-cycle bypass jobs, fifo fills
    repeat (20) @(posedge clk);
    if (resp_count == req_count && exp_q.size() == 0 && !res_req_o) begin
      $display("Test OK");
      $finish;
    end else begin
      $display("count mismatch: %0d requests, %0d results", req_count, resp_count);
      $display("Test FAILED");
      $fatal(1, "counts differ");
    end
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+testbench
hdl/div_pkg.sv
hdl/div_prep.sv
hdl/div_core.sv
hdl/div_result_fifo.sv
hdl/div_post.sv
hdl/div_unit.sv
testbench/div_unit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the divider testbench with verilator and run it
# the result is decided by the pass line in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module div_unit_tb -f all.f -o div_sim \
  && ./obj_dir/div_sim | tee /dev/stderr | grep -q "Test OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0
